// ==== common/color_sensor_pkg.sv ====
`default_nettype none

package color_sensor_pkg;

    // Width of the pulse count and of the latched frequency
    localparam int FREQ_W = 16;

    // Detected colour, codes as seen on the legacy colour bus
    typedef enum logic [1:0] {
        COLOR_RED   = 2'b00,
        COLOR_BLUE  = 2'b01,
        COLOR_NONE  = 2'b10,
        COLOR_GREEN = 2'b11
    } color_t;

    // Seven-segment pattern, active low, bit 6 first
    typedef logic [6:0] seg_t;

    localparam seg_t SEG_RED          = 7'b0000110; // Shown for red
    localparam seg_t SEG_GREEN        = 7'b0110000; // Shown for green
    localparam seg_t SEG_NONE_PATTERN = 7'b1011011; // Shown for code 10
    localparam seg_t SEG_OFF          = 7'b1111111; // All segments dark, used for blue

    // Measurement sequencer states
    typedef enum logic [1:0] {
        ST_IDLE   = 2'b00, // Waiting for enable
        ST_GATE   = 2'b01, // Counting edges in the window
        ST_LATCH  = 2'b10, // Count copied to frequency
        ST_DECIDE = 2'b11  // Classifier samples frequency
    } meas_state_t;

endpackage : color_sensor_pkg

`default_nettype wire

// ==== common/measure_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Window control from the FSM and the latched count from the counter
interface measure_if
    import color_sensor_pkg::*;
();

    logic              clear;     // Restart pulse count
    logic              latch;     // Copy count into frequency
    logic              decide;    // Classify latched frequency
    logic [FREQ_W-1:0] frequency; // Count of the last full window

    modport fsm (
        output clear,
        output latch,
        output decide,
        input  frequency  // Sampled for the top-level result
    );

    modport counter (
        input  clear,
        input  latch,
        output frequency
    );

    modport classifier (
        input decide,
        input frequency
    );

endinterface : measure_if

`default_nettype wire

// ==== src/ir_edge_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ir_edge_counter
    import color_sensor_pkg::*;
#(
    parameter int unsigned GATE_CYCLES = 100_000_000
) (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  ir_signal, // Asynchronous sensor output
    measure_if.counter meas
);

    // Fastest legal input toggles every cycle, plus slack for the latch overlap
    localparam int unsigned MAX_EDGES  = GATE_CYCLES / 2 + 2;
    localparam bit          SAT_NEEDED = MAX_EDGES >= (2 ** FREQ_W) - 1;
    localparam logic [FREQ_W-1:0] CNT_MAX = '1;

    logic [1:0]        sync_q;      // Two-flop synchroniser
    logic              prev_q;      // Last synchronised level
    logic              rise_q;      // Registered rising edge
    logic [FREQ_W-1:0] pulse_count; // Edges in current window
    logic              at_max;

    // Only reachable when the gate is long enough to overflow the count
    assign at_max = SAT_NEEDED && (pulse_count == CNT_MAX);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q <= '0;
            prev_q <= 1'b0;
            rise_q <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], ir_signal};  // Pin into first stage
            prev_q <= sync_q[1];
            rise_q <= sync_q[1] & ~prev_q;     // Low to high seen
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pulse_count    <= '0;
            meas.frequency <= '0;
        end else if (meas.latch) begin
            meas.frequency <= pulse_count;        // Close the window
            pulse_count    <= FREQ_W'(rise_q);    // Edge now belongs to next window
        end else if (meas.clear) begin
            pulse_count <= '0;                    // Frequency keeps last result
        end else if (rise_q && !at_max) begin
            pulse_count <= pulse_count + 1'b1;
        end
    end

endmodule : ir_edge_counter

`default_nettype wire

// ==== src/gate_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module gate_timer #(
    parameter int unsigned GATE_CYCLES = 100_000_000
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic gate_run, // Level, high while gating
    output logic      gate_end  // One cycle, last cycle of the window
);

    // At least one bit, even for a single-cycle gate
    localparam int CNT_W = (GATE_CYCLES > 1) ? $clog2(GATE_CYCLES) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(GATE_CYCLES - 1);

    logic [CNT_W-1:0] cycle_cnt; // Cycles elapsed in this window
    logic             at_last;

    assign at_last  = (cycle_cnt == LAST);
    assign gate_end = gate_run && at_last;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
        end else if (!gate_run) begin
            cycle_cnt <= '0;               // Held until the gate opens
        end else if (at_last) begin
            cycle_cnt <= '0;               // Wrap, next window back to back
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

endmodule : gate_timer

`default_nettype wire

// ==== src/measure_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module measure_fsm
    import color_sensor_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  wire logic         enable,       // Keep measuring while high
    input  wire logic         gate_end,     // From gate timer
    output logic              gate_run,     // To gate timer
    output logic              result_valid, // One cycle per finished window
    output logic [FREQ_W-1:0] frequency,    // Result, aligned with colour
    measure_if.fsm            meas
);

    meas_state_t state_q;
    meas_state_t state_d;
    logic        clear_q; // First cycle of a fresh gate

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (enable) begin
                    state_d = ST_GATE;
                end
            end
            ST_GATE: begin
                if (gate_end) begin
                    state_d = ST_LATCH;
                end
            end
            ST_LATCH: begin
                state_d = ST_DECIDE;              // Always one cycle
            end
            ST_DECIDE: begin
                // Disable only takes effect at a window boundary
                state_d = enable ? ST_GATE : ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q      <= ST_IDLE;
            clear_q      <= 1'b0;
            result_valid <= 1'b0;
            frequency    <= '0;
        end else begin
            state_q      <= state_d;
            clear_q      <= (state_q == ST_IDLE) && enable;  // Start from idle only
            result_valid <= meas.decide;                     // Same edge as classifier
            if (meas.decide) begin
                frequency <= meas.frequency;
            end
        end
    end

    // Latch restarts the count itself, so clear is needed only after idle
    assign meas.clear  = clear_q;
    assign meas.latch  = (state_q == ST_LATCH);
    assign meas.decide = (state_q == ST_DECIDE);
    assign gate_run    = (state_q == ST_GATE);

endmodule : measure_fsm

`default_nettype wire

// ==== classify/color_classifier.sv ====
`timescale 1ns/1ps
`default_nettype none

module color_classifier
    import color_sensor_pkg::*;
#(
    parameter int unsigned RED_MIN   = 900,
    parameter int unsigned RED_MAX   = 1100,
    parameter int unsigned GREEN_MIN = 1900,
    parameter int unsigned GREEN_MAX = 2100,
    parameter int unsigned BLUE_MIN  = 2900,
    parameter int unsigned BLUE_MAX  = 3100
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    measure_if.classifier meas,
    output color_t        color, // Last decided colour
    output seg_t          seg    // Pattern for that colour
);

    logic   is_red;
    logic   is_green;
    logic   is_blue;
    color_t color_d;
    seg_t   seg_d;

    // Inclusive bounds on both ends
    function automatic logic in_window(
        input logic [FREQ_W-1:0] freq,
        input int unsigned       lo,
        input int unsigned       hi
    );
        logic [31:0] f;
        f = 32'(freq);
        return (f >= lo) && (f <= hi);
    endfunction

    assign is_red   = in_window(meas.frequency, RED_MIN, RED_MAX);
    assign is_green = in_window(meas.frequency, GREEN_MIN, GREEN_MAX);
    assign is_blue  = in_window(meas.frequency, BLUE_MIN, BLUE_MAX);

    // Red wins over green, green over blue, if windows overlap
    always_comb begin
        if (is_red) begin
            color_d = COLOR_RED;
        end else if (is_green) begin
            color_d = COLOR_GREEN;
        end else if (is_blue) begin
            color_d = COLOR_BLUE;
        end else begin
            color_d = COLOR_NONE;
        end
    end

    always_comb begin
        case (color_d)
            COLOR_RED:   seg_d = SEG_RED;
            COLOR_GREEN: seg_d = SEG_GREEN;
            COLOR_NONE:  seg_d = SEG_NONE_PATTERN;
            default:     seg_d = SEG_OFF;      // Blue leaves the display dark
        endcase
    end

    // Both registered together, display never sees a mixed state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            color <= COLOR_NONE;
            seg   <= SEG_NONE_PATTERN;
        end else if (meas.decide) begin
            color <= color_d;
            seg   <= seg_d;
        end
    end

endmodule : color_classifier

`default_nettype wire

// ==== src/color_sensor_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module color_sensor_top
    import color_sensor_pkg::*;
#(
    parameter int unsigned GATE_CYCLES = 100_000_000, // One second at 100 MHz
    parameter int unsigned RED_MIN     = 900,
    parameter int unsigned RED_MAX     = 1100,
    parameter int unsigned GREEN_MIN   = 1900,
    parameter int unsigned GREEN_MAX   = 2100,
    parameter int unsigned BLUE_MIN    = 2900,
    parameter int unsigned BLUE_MAX    = 3100
) (
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  wire logic         enable,       // Run measurement windows
    input  wire logic         ir_signal,    // Raw sensor pulse train
    output logic              result_valid, // New result this cycle
    output color_t            color,
    output seg_t              seg,          // Active low segments
    output logic [FREQ_W-1:0] frequency     // Edges in last window
);

    measure_if meas ();

    logic gate_run;
    logic gate_end;

    ir_edge_counter #(
        .GATE_CYCLES (GATE_CYCLES)
    ) i_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .ir_signal (ir_signal),
        .meas      (meas.counter)
    );

    gate_timer #(
        .GATE_CYCLES (GATE_CYCLES)
    ) i_gate_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .gate_run (gate_run),
        .gate_end (gate_end)
    );

    measure_fsm i_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .enable       (enable),
        .gate_end     (gate_end),
        .gate_run     (gate_run),
        .result_valid (result_valid),
        .frequency    (frequency),
        .meas         (meas.fsm)
    );

    color_classifier #(
        .RED_MIN   (RED_MIN),
        .RED_MAX   (RED_MAX),
        .GREEN_MIN (GREEN_MIN),
        .GREEN_MAX (GREEN_MAX),
        .BLUE_MIN  (BLUE_MIN),
        .BLUE_MAX  (BLUE_MAX)
    ) i_classifier (
        .clk   (clk),
        .rst_n (rst_n),
        .meas  (meas.classifier),
        .color (color),
        .seg   (seg)
    );

endmodule : color_sensor_top

`default_nettype wire

// ==== verification/tb_color_sensor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_color_sensor
    import color_sensor_pkg::*;
();

    localparam int GATE_CYCLES    = 400;            // Short gate for simulation
    localparam int PERIOD         = GATE_CYCLES + 2; // Cycles between results
    localparam int RED_MIN        = 30;
    localparam int RED_MAX        = 40;
    localparam int GREEN_MIN      = 70;
    localparam int GREEN_MAX      = 80;
    localparam int BLUE_MIN       = 110;
    localparam int BLUE_MAX       = 120;
    localparam int NUM_WIN        = 40;
    localparam int MAX_WIN        = NUM_WIN + 4;    // Edges after the stop land here
    localparam int MAX_TARGET     = 130;
    localparam int NUM_CORNERS    = 16;
    localparam int RESET_CYCLES   = 10;
    localparam int IDLE_CYCLES    = 20;
    localparam int RESULT_TIMEOUT = 2 * PERIOD;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              enable;
    logic              ir_signal;
    logic              result_valid;
    color_t            color;
    seg_t              seg;
    logic [FREQ_W-1:0] frequency;

    // Threshold values and their neighbours first, random targets after
    int corner_targets [NUM_CORNERS] = '{
        0, 29, 30, 40, 41, 69, 70, 80, 81, 109, 110, 120, 121, 130, 35, 115
    };

    int                model_count [MAX_WIN]; // Edges per window in the model
    int                cyc = 0;               // Posedges since time zero
    int                rel = 0;               // Posedges since enable was seen
    bit                started = 1'b0;
    logic              ir_last = 1'b0;
    logic [31:0]       rng_state = 32'd1;
    int                win_pos;               // Cycle within the driven window
    int                drop_pos;              // Where enable falls, -1 for never
    bit                aborted = 1'b0;
    int                err_color = 0;
    int                err_seg = 0;
    int                err_freq = 0;
    int                err_valid = 0;
    int                err_gap = 0;
    int                err_other = 0;
    color_t            last_color;
    seg_t              last_seg;
    logic [FREQ_W-1:0] last_freq;

    color_sensor_top #(
        .GATE_CYCLES (GATE_CYCLES),
        .RED_MIN     (RED_MIN),
        .RED_MAX     (RED_MAX),
        .GREEN_MIN   (GREEN_MIN),
        .GREEN_MAX   (GREEN_MAX),
        .BLUE_MIN    (BLUE_MIN),
        .BLUE_MAX    (BLUE_MAX)
    ) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .enable       (enable),
        .ir_signal    (ir_signal),
        .result_valid (result_valid),
        .color        (color),
        .seg          (seg),
        .frequency    (frequency)
    );

    always #50 clk = ~clk; // 100 ns period

    // Reference model, bins every rising edge into its gate window
    always @(posedge clk) begin : model_step
        int r;
        int w;
        cyc = cyc + 1;
        if (rst_n) begin
            if (started) begin
                rel = rel + 1;
            end else if (enable) begin
                started = 1'b1;                 // FSM leaves idle on this edge
                rel     = 0;
            end
            if (started && ir_signal && !ir_last) begin
                r = rel + 3;                    // Two sync flops plus edge stage
                w = (r + 1) / PERIOD;           // Latch edge opens the next window
                if (r >= 2 && w < MAX_WIN) begin // Clear drops the first two edges
                    model_count[w] = model_count[w] + 1;
                end
            end
            ir_last = ir_signal;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw(input int range, output int val);
        rng_state = xorshift32(rng_state);
        val = int'(rng_state % range);
    endtask

    // Inclusive windows, red before green before blue
    function automatic color_t expect_color(input int f);
        if (f >= RED_MIN && f <= RED_MAX) begin
            return COLOR_RED;
        end else if (f >= GREEN_MIN && f <= GREEN_MAX) begin
            return COLOR_GREEN;
        end else if (f >= BLUE_MIN && f <= BLUE_MAX) begin
            return COLOR_BLUE;
        end
        return COLOR_NONE;
    endfunction

    function automatic seg_t expect_seg(input color_t c);
        case (c)
            COLOR_RED:   return SEG_RED;
            COLOR_GREEN: return SEG_GREEN;
            COLOR_NONE:  return SEG_NONE_PATTERN;
            default:     return SEG_OFF;        // Blue shows nothing
        endcase
    endfunction

    task automatic check_color(input color_t got, input color_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED color: got %h expected %h at %0t", got, exp, $time);
            err_color++;
        end
    endtask

    task automatic check_seg(input seg_t got, input seg_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED seg: got %h expected %h at %0t", got, exp, $time);
            err_seg++;
        end
    endtask

    task automatic check_freq(input logic [FREQ_W-1:0] got, input logic [FREQ_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED frequency: got %h expected %h at %0t", got, exp, $time);
            err_freq++;
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED result_valid: got %h expected %h at %0t", got, exp, $time);
            err_valid++;
        end
    endtask

    task automatic check_gap(input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED result_valid period: got %h expected %h at %0t",
                     got, exp, $time);
            err_gap++;
        end
    endtask

    // One value per cycle, enable falls once the drop point is reached
    task automatic drive_level(input logic v, input int cycles);
        int c;
        for (c = 0; c < cycles; c++) begin
            if (win_pos == drop_pos) begin
                enable = 1'b0;
            end
            ir_signal = v;
            win_pos++;
            @(negedge clk);
        end
    endtask

    // Exactly n pulses in len cycles, each starting low
    task automatic drive_window(input int n, input int len, input int drop_at);
        int p;
        int slack;
        int lo;
        int hi_t;
        int extra;
        int i;
        win_pos  = 0;
        drop_pos = drop_at;
        slack    = len;
        if (n > 0) begin
            p     = len / n;
            slack = len - n * p;
            lo    = (p >= 4) ? 2 : 1;            // Dense targets need 1-cycle phases
            for (i = 0; i < n; i++) begin
                draw(p - 2 * lo + 1, hi_t);
                hi_t = hi_t + lo;
                draw(slack + 1, extra);          // Spare cycles widen random gaps
                slack = slack - extra;
                drive_level(1'b0, p - hi_t + extra);
                drive_level(1'b1, hi_t);
            end
        end
        drive_level(1'b0, slack);
    endtask

    task automatic drive_stimulus();
        int w;
        int n;
        int len;
        int drop_at;
        enable = 1'b1;
        for (w = 0; w < NUM_WIN; w++) begin
            if (w < NUM_CORNERS) begin
                n = corner_targets[w];
            end else begin
                draw(MAX_TARGET + 1, n);
            end
            len     = (w == 0) ? GATE_CYCLES - 2 : PERIOD; // First window loses the clear
            drop_at = (w == NUM_WIN - 1) ? len / 2 : -1;   // Stop mid-window
            drive_window(n, len, drop_at);
        end
        ir_signal = 1'b0;
    endtask

    task automatic wait_result(output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < RESULT_TIMEOUT) begin
            @(negedge clk);
            n++;
            if (result_valid) begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic collect_results();
        int     w;
        int     last_cyc;
        bit     ok;
        color_t exp_c;
        last_cyc = 0;
        for (w = 0; w < NUM_WIN && !aborted; w++) begin
            wait_result(ok);
            if (!ok) begin
                $display("Timed out waiting for the result of window %0d", w);
                err_other++;
                aborted = 1'b1;
            end else begin
                exp_c = expect_color(model_count[w]);
                check_freq(frequency, FREQ_W'(model_count[w]));
                check_color(color, exp_c);
                check_seg(seg, expect_seg(exp_c));
                if (w > 0) begin
                    check_gap(cyc - last_cyc, PERIOD);
                end
                last_cyc   = cyc;
                last_color = exp_c;                      // Model result of this window
                last_seg   = expect_seg(exp_c);
                last_freq  = FREQ_W'(model_count[w]);
            end
        end
    endtask

    // Nothing may change while the sequencer is stopped
    task automatic check_hold(input int cycles, input color_t c, input seg_t s,
                              input logic [FREQ_W-1:0] f);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_valid(result_valid, 1'b0);
            check_color(color, c);
            check_seg(seg, s);
            check_freq(frequency, f);
        end
    endtask

    initial begin : main
        int i;
        int total;
        for (i = 0; i < MAX_WIN; i++) begin
            model_count[i] = 0;
        end
        rst_n     = 1'b0;
        enable    = 1'b0;
        ir_signal = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        check_hold(IDLE_CYCLES, COLOR_NONE, SEG_NONE_PATTERN, '0); // Reset values, idle

        fork
            drive_stimulus();
            collect_results();
        join

        if (!aborted) begin
            check_hold(3 * PERIOD, last_color, last_seg, last_freq);
        end

        total = err_color + err_seg + err_freq + err_valid + err_gap + err_other;
        $display("errors: color=%0d seg=%0d frequency=%0d valid=%0d period=%0d other=%0d",
                 err_color, err_seg, err_freq, err_valid, err_gap, err_other);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : tb_color_sensor

`default_nettype wire

// ==== list.f ====
common/color_sensor_pkg.sv
common/measure_if.sv
src/ir_edge_counter.sv
src/gate_timer.sv
src/measure_fsm.sv
classify/color_classifier.sv
src/color_sensor_top.sv
verification/tb_color_sensor.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the colour sensor testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_color_sensor
OBJ_DIR=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing -f list.f --top-module "$TOP" --Mdir "$OBJ_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$("./$OBJ_DIR/V$TOP")
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Result is taken from the printed pass line only
if printf '%s\n' "$output" | grep -qx "test passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
